// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = tb_id_stage
FLIST = tb.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)

run: build
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ) $(LOG)

// File: bench/tb_encode.svh
`ifndef TB_ENCODE_SVH
`define TB_ENCODE_SVH

function automatic word_t r3_word(logic [4:0] op, reg_addr_t rd, reg_addr_t rj, reg_addr_t rk);
    return {6'h00, 4'h0, 2'h1, op, rk, rj, rd};
endfunction

// major opcode 0x00 for arithmetic immediates, 0x0a for loads and stores.
function automatic word_t ri12_word(logic [5:0] major, logic [3:0] minor, logic [11:0] imm,
                                    reg_addr_t rj, reg_addr_t rd);
    return {major, minor, imm, rj, rd};
endfunction

function automatic word_t br16_word(logic [5:0] op, logic [15:0] offs, reg_addr_t rj,
                                    reg_addr_t rd);
    return {op, offs, rj, rd};
endfunction

function automatic word_t sext12(logic [11:0] x);
    return {{20{x[11]}}, x};
endfunction

function automatic word_t offs16_target(word_t base, logic [15:0] offs);
    return base + {{14{offs[15]}}, offs, 2'b00};
endfunction

function automatic logic cond_taken(logic [5:0] op, word_t a, word_t b);
    case (op)
        6'h16: return a == b;
        6'h17: return a != b;
        6'h18: return $signed(a) < $signed(b);
        6'h19: return $signed(a) >= $signed(b);
        6'h1a: return a < b;
        default: return a >= b;
    endcase
endfunction

`endif

// File: bench/tb_id_stage.sv
module tb_id_stage
    import isa_pkg::*;
    import pipe_pkg::*;
;
    `include "tb_encode.svh"

    localparam int DECODE_N = 40;
    localparam int BR_N     = 24;
    localparam int BP_N     = 24;
    localparam int LIMIT    = 2 * (10 + DECODE_N * 4 + 40 + BR_N * 5 + BP_N * 4);
    localparam logic [4:0] R3_OP [11] = '{5'h00, 5'h02, 5'h04, 5'h05, 5'h08, 5'h09,
                                           5'h0a, 5'h0b, 5'h0e, 5'h0f, 5'h10};
    localparam int R3_ALU [11] = '{ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_NOR, ALU_AND,
                                   ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA};
    localparam logic [3:0] RI_OP [6] = '{4'h8, 4'h9, 4'ha, 4'hd, 4'he, 4'hf};
    localparam int RI_ALU [6] = '{ALU_SLT, ALU_SLTU, ALU_ADD, ALU_AND, ALU_OR, ALU_XOR};
    localparam logic [3:0] MEM_OP [8] = '{4'h0, 4'h1, 4'h2, 4'h8, 4'h9, 4'h4, 4'h5, 4'h6};
    localparam mem_size_t MEM_SZ [8] = '{MEM_BYTE, MEM_HALF, MEM_WORD, MEM_BYTE, MEM_HALF,
                                         MEM_BYTE, MEM_HALF, MEM_WORD};

    logic clk, rst, if_valid, id_allow_in, ex_allow_in, ex_valid, ex_is_load;
    if_id_t if_data;
    id_ex_t ex_data;
    br_t br;
    reg_addr_t rf_raddr1, rf_raddr2;
    word_t rf_rdata1, rf_rdata2;
    fwd_t ex_fwd, mem_fwd, wb_fwd;
    int errors = 0;
    int cycles = 0;

    id_stage dut (.*);

    // register file model, each register holds its index in every byte.
    assign rf_rdata1 = word_t'(rf_raddr1) * 32'h01010101;
    assign rf_rdata2 = word_t'(rf_raddr2) * 32'h01010101;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > LIMIT) begin
            $display("timeout: the run went past %0d cycles", LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    task automatic expect_true(logic ok, string what);
        a_check: assert (ok) else begin
            errors++;
            $display("FAIL t=%0t: %s", $time, what);
        end
    endtask

    a_hold: assert property (@(posedge clk) disable iff (rst)
        ex_valid && !ex_allow_in |=> ex_valid && $stable(ex_data))
        else expect_true(1'b0, "ex_data moved under back-pressure");
    a_reset: assert property (@(posedge clk) rst |=> !ex_valid && !br.taken && id_allow_in)
        else expect_true(1'b0, "stage not idle after reset");

    // returns at the falling edge after acceptance, with the instruction latched.
    task automatic send(word_t pc, word_t inst);
        @(negedge clk);
        if_valid = 1'b1;
        if_data = '{pc: pc, inst: inst};
        #1;
        while (!id_allow_in) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        if_valid = 1'b0;
        #1;
    endtask

    task automatic set_bypass(fwd_t ex, fwd_t mem, fwd_t wb, logic load);
        @(negedge clk);
        ex_fwd = ex;
        mem_fwd = mem;
        wb_fwd = wb;
        ex_is_load = load;
    endtask

    task automatic decode_test();
        word_t inst, e_imm;
        alu_op_t e_alu;
        mem_size_t e_ld, e_st;
        logic e_we, e_inv, e_lds, e_s1p, e_s2i, imm_chk;
        reg_addr_t rd, rj, rk;
        logic [11:0] i12;
        int k;
        for (int n = 0; n < DECODE_N; n++) begin
            rd = reg_addr_t'($urandom);
            rj = reg_addr_t'($urandom);
            rk = reg_addr_t'($urandom);
            i12 = 12'($urandom);
            k = $urandom_range(0, 10);
            e_alu = '0;
            e_ld = MEM_NONE;
            e_st = MEM_NONE;
            e_lds = 1'b0;
            e_we = 1'b1;
            e_inv = 1'b0;
            e_s1p = 1'b0;
            e_s2i = 1'b0;
            imm_chk = 1'b1;
            e_imm = sext12(i12);
            case (n % 5)
                0: begin
                    inst = r3_word(R3_OP[k], rd, rj, rk);
                    e_alu[R3_ALU[k]] = 1'b1;
                    imm_chk = 1'b0;  // register forms carry no immediate.
                end
                1: begin
                    inst = ri12_word(6'h00, RI_OP[k % 6], i12, rj, rd);
                    e_alu[RI_ALU[k % 6]] = 1'b1;
                    e_s2i = 1'b1;
                    if (k % 6 >= 3) e_imm = {20'b0, i12};
                end
                2: begin
                    if (k % 2 == 0) begin
                        inst = {7'h0a, i12, 8'($urandom), rd};
                        e_alu[ALU_LUI] = 1'b1;
                    end else begin
                        inst = {7'h0e, i12, 8'($urandom), rd};
                        e_alu[ALU_ADD] = 1'b1;
                        e_s1p = 1'b1;
                    end
                    e_s2i = 1'b1;
                    e_imm = {inst[24:5], 12'b0};
                end
                3: begin
                    inst = ri12_word(6'h0a, MEM_OP[k % 8], i12, rj, rd);
                    e_alu[ALU_ADD] = 1'b1;
                    e_s2i = 1'b1;
                    if (k % 8 < 5) e_ld = MEM_SZ[k % 8];
                    else e_st = MEM_SZ[k % 8];
                    e_lds = k % 8 < 3;
                    e_we = k % 8 < 5;
                end
                default: begin
                    inst = {6'h3c | 6'(k % 4), 26'($urandom)};
                    e_we = 1'b0;
                    e_inv = 1'b1;
                    imm_chk = 1'b0;
                end
            endcase
            send(word_t'(n * 4), inst);
            expect_true(ex_valid && ex_data.alu_op == e_alu &&
                        (!imm_chk || ex_data.imm == e_imm),
                        $sformatf("decode %h: alu_op %h imm %h", inst, ex_data.alu_op,
                                  ex_data.imm));
            expect_true(ex_data.src1_is_pc == e_s1p && ex_data.src2_is_imm == e_s2i,
                        $sformatf("decode %h: src1_is_pc %b src2_is_imm %b", inst,
                                  ex_data.src1_is_pc, ex_data.src2_is_imm));
            expect_true(ex_data.ld_size == e_ld && ex_data.ld_signed == e_lds &&
                        ex_data.st_size == e_st, $sformatf("decode %h: mem sizes", inst));
            expect_true(ex_data.gr_we == e_we && ex_data.invalid == e_inv &&
                        ex_data.dest == (e_we ? rd : reg_addr_t'(0)),
                        $sformatf("decode %h: we %b dest %0d", inst, ex_data.gr_we,
                                  ex_data.dest));
        end
        $display("decode test done, %0d errors so far", errors);
    endtask

    task automatic forward_case(word_t inst, fwd_t ex, fwd_t mem, fwd_t wb, word_t rj_exp,
                                word_t rkd_exp);
        set_bypass(ex, mem, wb, 1'b0);
        send(32'h100, inst);
        expect_true(ex_valid && ex_data.rj_value == rj_exp && ex_data.rkd_value == rkd_exp,
                    $sformatf("forward %h: rj %h rkd %h", inst, ex_data.rj_value,
                              ex_data.rkd_value));
    endtask

    task automatic forward_test();
        word_t add5;
        add5 = r3_word(5'h00, 5'd9, 5'd5, 5'd6);
        forward_case(add5, '{5, 32'ha, 1}, '{5, 32'hb, 1}, '{5, 32'hc, 1}, 32'ha, 32'h06060606);
        forward_case(add5, '{0, 32'ha, 0}, '{5, 32'hb, 1}, '{5, 32'hc, 1}, 32'hb, 32'h06060606);
        forward_case(add5, '{6, 32'hd, 1}, '{0, 32'h0, 0}, '{5, 32'hc, 1}, 32'hc, 32'hd);
        forward_case(add5, '{5, 32'ha, 0}, '{5, 32'hb, 1}, '{0, 32'h0, 0}, 32'hb, 32'h06060606);
        forward_case(r3_word(5'h00, 5'd9, 5'd0, 5'd6), '{0, 32'ha, 1}, '{0, 32'hb, 1},
                     '{0, 32'hc, 1}, 32'h0, 32'h06060606);
        forward_case(ri12_word(6'h00, 4'ha, 12'h006, 5'd5, 5'd9), '{6, 32'ha, 1},
                     '{0, 32'h0, 0}, '{0, 32'h0, 0}, 32'h05050505, 32'h06060606);
        set_bypass('0, '0, '0, 1'b0);
        $display("forwarding test done, %0d errors so far", errors);
    endtask

    task automatic load_use_test();
        set_bypass('{5, 32'h0bad, 1}, '0, '0, 1'b1);
        send(32'h200, r3_word(5'h00, 5'd9, 5'd5, 5'd6));
        repeat (3) begin
            expect_true(!ex_valid && !id_allow_in, "load-use: stalled instruction went on");
            @(negedge clk);
            #1;
        end
        ex_is_load = 1'b0;
        ex_fwd.value = 32'h1234;
        #1;
        expect_true(ex_valid && ex_data.rj_value == 32'h1234,
                    $sformatf("load-use: rj %h after the stall", ex_data.rj_value));
        set_bypass('{7, 32'h0bad, 1}, '0, '0, 1'b1);
        send(32'h204, r3_word(5'h00, 5'd9, 5'd5, 5'd6));
        expect_true(ex_valid, "load-use: unrelated load stalled the stage");
        set_bypass('0, '0, '0, 1'b0);
        $display("load-use test done, %0d errors so far", errors);
    endtask

    task automatic branch_test();
        word_t a, b, pc, inst, target;
        logic [5:0] op;
        logic [15:0] offs;
        logic taken;
        reg_addr_t rj;
        for (int n = 0; n < BR_N; n++) begin
            rj = reg_addr_t'($urandom_range(1, 15));
            a = word_t'($urandom);
            b = $urandom_range(0, 2) == 0 ? a : word_t'($urandom);
            op = 6'h13 + 6'(n % 9);
            offs = 16'($urandom);
            pc = word_t'($urandom) & ~32'h3;
            set_bypass('0, '{rj, a, 1}, '{rj + 16, b, 1}, 1'b0);
            inst = br16_word(op, offs, rj, rj + 16);
            taken = op < 6'h16 ? 1'b1 : cond_taken(op, a, b);
            target = op == 6'h13 ? offs16_target(a, offs) :
                     op < 6'h16 ? pc + {{4{inst[9]}}, inst[9:0], offs, 2'b00} :
                     offs16_target(pc, offs);
            send(pc, inst);
            if_valid = 1'b1;
            if_data = '{pc: pc + 4, inst: r3_word(5'h00, 5'd1, 5'd2, 5'd3)};
            #1;
            expect_true(ex_valid && br.taken == taken && (!taken || br.target == target),
                        $sformatf("branch %h: taken %b target %h", inst, br.taken,
                                  br.target));
            @(negedge clk);
            if_valid = 1'b0;
            #1;
            expect_true(ex_valid == !taken, $sformatf("branch %h: wrong follower", inst));
        end
        set_bypass('0, '0, '0, 1'b0);
        $display("branch test done, %0d errors so far", errors);
    endtask

    task automatic back_pressure_test();
        int sent, got;
        sent = 0;
        got = 0;
        while (got < BP_N) begin
            @(negedge clk);
            ex_allow_in = 1'($urandom_range(0, 1));
            if_valid = sent < BP_N;
            if_data = '{pc: word_t'(sent * 4), inst: r3_word(5'h00, 5'd1, 5'd2, 5'd3)};
            #1;
            if (ex_valid && ex_allow_in) begin
                expect_true(ex_data.pc == word_t'(got * 4),
                            $sformatf("back-pressure: pc %h, item %0d", ex_data.pc, got));
                got++;
            end
            if (ex_valid && !ex_allow_in) expect_true(!id_allow_in, "back-pressure: allow-in");
            if (if_valid && id_allow_in) sent++;
        end
        @(negedge clk);
        if_valid = 1'b0;
        ex_allow_in = 1'b1;
        $display("back-pressure test done, %0d errors so far", errors);
    endtask

    initial begin
        void'($urandom(41015));
        rst = 1'b1;
        if_valid = 1'b0;
        if_data = '0;
        ex_allow_in = 1'b1;
        ex_is_load = 1'b0;
        ex_fwd = '0;
        mem_fwd = '0;
        wb_fwd = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        expect_true(!ex_valid && !br.taken && id_allow_in, "reset: stage not idle");
        $display("reset test done, %0d errors so far", errors);
        decode_test();
        forward_test();
        load_use_test();
        branch_test();
        back_pressure_test();
        $display("tests 6, errors %0d, cycles %0d", errors, cycles);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: source/branch_resolve.sv
module branch_resolve
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  dec_ctrl_t ctrl,
    input  word_t     pc,
    input  word_t     rj_value,
    input  word_t     rkd_value,
    input  logic      active,
    output br_t       br
);

    logic  rj_eq;
    logic  rj_lt;
    logic  rj_ltu;
    logic  cond;
    logic  uncond;
    word_t offs16;
    word_t offs26;

    assign rj_eq  = rj_value == rkd_value;
    assign rj_lt  = $signed(rj_value) < $signed(rkd_value);
    assign rj_ltu = rj_value < rkd_value;

    assign cond = ctrl.br_kind.beq  &  rj_eq
                | ctrl.br_kind.bne  & ~rj_eq
                | ctrl.br_kind.blt  &  rj_lt
                | ctrl.br_kind.bge  & ~rj_lt
                | ctrl.br_kind.bltu &  rj_ltu
                | ctrl.br_kind.bgeu & ~rj_ltu;
    assign uncond = ctrl.br_kind.b | ctrl.br_kind.bl | ctrl.br_kind.jirl;

    assign offs16 = {{14{ctrl.br_offs[15]}}, ctrl.br_offs[15:0], 2'b00};
    assign offs26 = {{4{ctrl.br_offs[25]}}, ctrl.br_offs, 2'b00};

    assign br.taken  = active & (cond | uncond);
    assign br.target = ctrl.br_kind.jirl ? rj_value + offs16 :
                       (ctrl.br_kind.b | ctrl.br_kind.bl) ? pc + offs26 : pc + offs16;

    always_comb begin
        a_taken_kind: assert final (!br.taken || $onehot(ctrl.br_kind));
    end

endmodule

// File: source/id_defines.svh
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

// Datapath word width.
`define XLEN 32

// Width of a general register index.
`define REG_AW 5

// Number of ALU operation bits in the one-hot select.
`define ALU_OPS 12

// Register r0 reads as zero and is never a hazard source.
`define ZERO_REG 0

`endif

// File: source/id_stage.sv
module id_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      if_valid,
    input  if_id_t    if_data,
    output logic      id_allow_in,
    input  logic      ex_allow_in,
    output logic      ex_valid,
    output id_ex_t    ex_data,
    output br_t       br,
    output reg_addr_t rf_raddr1,
    output reg_addr_t rf_raddr2,
    input  word_t     rf_rdata1,
    input  word_t     rf_rdata2,
    input  fwd_t      ex_fwd,
    input  fwd_t      mem_fwd,
    input  fwd_t      wb_fwd,
    input  logic      ex_is_load
);

    logic      id_valid;
    if_id_t    id_data;
    dec_ctrl_t ctrl;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    logic      uses_rj;
    logic      uses_rkd;
    logic      stall;
    logic      ready_go;
    word_t     rj_value;
    word_t     rkd_value;

    assign ready_go    = ~stall;
    assign id_allow_in = ~id_valid | (ready_go & ex_allow_in);
    assign ex_valid    = id_valid & ready_go;

    // a taken branch drops the next fetch once the branch itself has left.
    always_ff @(posedge clk) begin
        if (rst) begin
            id_valid <= 1'b0;
        end else if (br.taken && ex_allow_in) begin
            id_valid <= 1'b0;
        end else if (id_allow_in) begin
            id_valid <= if_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_valid && id_allow_in) begin
            id_data <= if_data;
        end
    end

    inst_decoder u_dec (
        .inst     (id_data.inst),
        .ctrl     (ctrl),
        .raddr1   (raddr1),
        .raddr2   (raddr2),
        .uses_rj  (uses_rj),
        .uses_rkd (uses_rkd)
    );

    operand_forward u_fwd (
        .raddr1     (raddr1),
        .raddr2     (raddr2),
        .uses_rj    (uses_rj),
        .uses_rkd   (uses_rkd),
        .rf_rdata1  (rf_rdata1),
        .rf_rdata2  (rf_rdata2),
        .ex_fwd     (ex_fwd),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_fwd),
        .ex_is_load (ex_is_load),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .stall      (stall)
    );

    branch_resolve u_br (
        .ctrl      (ctrl),
        .pc        (id_data.pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .active    (id_valid & ready_go),
        .br        (br)
    );

    assign rf_raddr1 = raddr1;
    assign rf_raddr2 = raddr2;

    always_comb begin
        ex_data.pc          = id_data.pc;
        ex_data.rj_value    = rj_value;
        ex_data.rkd_value   = rkd_value;
        ex_data.imm         = ctrl.imm;
        ex_data.alu_op      = ctrl.alu_op;
        ex_data.src1_is_pc  = ctrl.src1_is_pc;
        ex_data.src2_is_imm = ctrl.src2_is_imm;
        ex_data.ld_size     = ctrl.ld_size;
        ex_data.ld_signed   = ctrl.ld_signed;
        ex_data.st_size     = ctrl.st_size;
        ex_data.dest        = ctrl.dest;
        ex_data.gr_we       = ctrl.gr_we;
        ex_data.invalid     = ctrl.invalid;
    end

    a_hold_payload: assert property (@(posedge clk) disable iff (rst)
        ex_valid && !ex_allow_in |=> ex_valid && $stable(ex_data));

    a_no_branch_in_stall: assert property (@(posedge clk) disable iff (rst)
        stall |-> !br.taken);

endmodule

// File: source/inst_decoder.sv
`include "id_defines.svh"

module inst_decoder
    import isa_pkg::*;
(
    input  word_t     inst,
    output dec_ctrl_t ctrl,
    output reg_addr_t raddr1,
    output reg_addr_t raddr2,
    output logic      uses_rj,
    output logic      uses_rkd
);

    inst_fields_t f;
    logic         op_zero;
    logic         op_3r;
    logic         op_shi;
    logic         op_mem;
    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu, inst_nor, inst_and;
    logic inst_or, inst_xor, inst_sll_w, inst_srl_w, inst_sra_w;
    logic inst_slli_w, inst_srli_w, inst_srai_w, inst_slti, inst_sltui;
    logic inst_addi_w, inst_andi, inst_ori, inst_xori, inst_lu12i_w, inst_pcaddu12i;
    logic inst_ld_b, inst_ld_h, inst_ld_w, inst_ld_bu, inst_ld_hu;
    logic inst_st_b, inst_st_h, inst_st_w;
    logic inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;
    logic inst_blt, inst_bge, inst_bltu, inst_bgeu;
    logic is_3r, is_load, is_store, is_cond_br;
    logic need_si20, need_ui12, src2_is_4, known;
    word_t imm;

    assign f = inst;

    assign op_zero = f.op_31_26 == 6'h00;
    assign op_3r   = op_zero && f.op_25_22 == 4'h0 && f.op_21_20 == 2'h1;
    assign op_shi  = op_zero && f.op_25_22 == 4'h1 && f.op_21_20 == 2'h0;
    assign op_mem  = f.op_31_26 == 6'h0a;

    assign inst_add_w     = op_3r && f.op_19_15 == 5'h00;
    assign inst_sub_w     = op_3r && f.op_19_15 == 5'h02;
    assign inst_slt       = op_3r && f.op_19_15 == 5'h04;
    assign inst_sltu      = op_3r && f.op_19_15 == 5'h05;
    assign inst_nor       = op_3r && f.op_19_15 == 5'h08;
    assign inst_and       = op_3r && f.op_19_15 == 5'h09;
    assign inst_or        = op_3r && f.op_19_15 == 5'h0a;
    assign inst_xor       = op_3r && f.op_19_15 == 5'h0b;
    assign inst_sll_w     = op_3r && f.op_19_15 == 5'h0e;
    assign inst_srl_w     = op_3r && f.op_19_15 == 5'h0f;
    assign inst_sra_w     = op_3r && f.op_19_15 == 5'h10;
    assign inst_slli_w    = op_shi && f.op_19_15 == 5'h01;
    assign inst_srli_w    = op_shi && f.op_19_15 == 5'h09;
    assign inst_srai_w    = op_shi && f.op_19_15 == 5'h11;
    assign inst_slti      = op_zero && f.op_25_22 == 4'h8;
    assign inst_sltui     = op_zero && f.op_25_22 == 4'h9;
    assign inst_addi_w    = op_zero && f.op_25_22 == 4'ha;
    assign inst_andi      = op_zero && f.op_25_22 == 4'hd;
    assign inst_ori       = op_zero && f.op_25_22 == 4'he;
    assign inst_xori      = op_zero && f.op_25_22 == 4'hf;
    assign inst_lu12i_w   = f.op_31_26 == 6'h05 && !f.op_25_22[3];
    assign inst_pcaddu12i = f.op_31_26 == 6'h07 && !f.op_25_22[3];
    assign inst_ld_b      = op_mem && f.op_25_22 == 4'h0;
    assign inst_ld_h      = op_mem && f.op_25_22 == 4'h1;
    assign inst_ld_w      = op_mem && f.op_25_22 == 4'h2;
    assign inst_st_b      = op_mem && f.op_25_22 == 4'h4;
    assign inst_st_h      = op_mem && f.op_25_22 == 4'h5;
    assign inst_st_w      = op_mem && f.op_25_22 == 4'h6;
    assign inst_ld_bu     = op_mem && f.op_25_22 == 4'h8;
    assign inst_ld_hu     = op_mem && f.op_25_22 == 4'h9;
    assign inst_jirl      = f.op_31_26 == 6'h13;
    assign inst_b         = f.op_31_26 == 6'h14;
    assign inst_bl        = f.op_31_26 == 6'h15;
    assign inst_beq       = f.op_31_26 == 6'h16;
    assign inst_bne       = f.op_31_26 == 6'h17;
    assign inst_blt       = f.op_31_26 == 6'h18;
    assign inst_bge       = f.op_31_26 == 6'h19;
    assign inst_bltu      = f.op_31_26 == 6'h1a;
    assign inst_bgeu      = f.op_31_26 == 6'h1b;

    assign is_3r = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor | inst_and
                 | inst_or | inst_xor | inst_sll_w | inst_srl_w | inst_sra_w;
    assign is_load    = inst_ld_b | inst_ld_h | inst_ld_w | inst_ld_bu | inst_ld_hu;
    assign is_store   = inst_st_b | inst_st_h | inst_st_w;
    assign is_cond_br = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;
    assign known = is_3r | is_load | is_store | is_cond_br
                 | inst_slli_w | inst_srli_w | inst_srai_w | inst_slti | inst_sltui
                 | inst_addi_w | inst_andi | inst_ori | inst_xori | inst_lu12i_w
                 | inst_pcaddu12i | inst_jirl | inst_b | inst_bl;

    assign need_si20 = inst_lu12i_w | inst_pcaddu12i;
    assign need_ui12 = inst_andi | inst_ori | inst_xori;
    assign src2_is_4 = inst_jirl | inst_bl;  // link value is pc plus 4.

    assign imm = src2_is_4 ? 32'd4 :
                 need_si20 ? {inst[24:5], 12'b0} :
                 need_ui12 ? {20'b0, inst[21:10]} :
                             {{20{inst[21]}}, inst[21:10]};

    assign raddr1   = f.rj;
    assign raddr2   = (is_cond_br | is_store) ? f.rd : f.rk;  // these read rd as data.
    assign uses_rj  = known & ~(inst_lu12i_w | inst_pcaddu12i | inst_b | inst_bl);
    assign uses_rkd = is_3r | is_store | is_cond_br;

    always_comb begin
        ctrl.alu_op           = '0;
        ctrl.alu_op[ALU_ADD]  = inst_add_w | inst_addi_w | is_load | is_store
                              | inst_jirl | inst_bl | inst_pcaddu12i;
        ctrl.alu_op[ALU_SUB]  = inst_sub_w;
        ctrl.alu_op[ALU_SLT]  = inst_slt | inst_slti;
        ctrl.alu_op[ALU_SLTU] = inst_sltu | inst_sltui;
        ctrl.alu_op[ALU_AND]  = inst_and | inst_andi;
        ctrl.alu_op[ALU_NOR]  = inst_nor;
        ctrl.alu_op[ALU_OR]   = inst_or | inst_ori;
        ctrl.alu_op[ALU_XOR]  = inst_xor | inst_xori;
        ctrl.alu_op[ALU_SLL]  = inst_sll_w | inst_slli_w;
        ctrl.alu_op[ALU_SRL]  = inst_srl_w | inst_srli_w;
        ctrl.alu_op[ALU_SRA]  = inst_sra_w | inst_srai_w;
        ctrl.alu_op[ALU_LUI]  = inst_lu12i_w;
        ctrl.src1_is_pc  = inst_jirl | inst_bl | inst_pcaddu12i;
        ctrl.src2_is_imm = known & ~is_3r & ~is_cond_br & ~inst_b;
        ctrl.ld_size     = inst_ld_w ? MEM_WORD :
                           (inst_ld_h | inst_ld_hu) ? MEM_HALF :
                           (inst_ld_b | inst_ld_bu) ? MEM_BYTE : MEM_NONE;
        ctrl.ld_signed   = inst_ld_b | inst_ld_h | inst_ld_w;
        ctrl.st_size     = inst_st_w ? MEM_WORD :
                           inst_st_h ? MEM_HALF :
                           inst_st_b ? MEM_BYTE : MEM_NONE;
        ctrl.gr_we       = known & ~is_store & ~inst_b & ~is_cond_br;
        ctrl.dest        = !ctrl.gr_we ? `REG_AW'(`ZERO_REG) :
                           inst_bl     ? `REG_AW'(1) : f.rd;
        ctrl.imm         = imm;
        ctrl.br_kind     = '{jirl: inst_jirl, b: inst_b, bl: inst_bl, beq: inst_beq,
                             bne: inst_bne, blt: inst_blt, bge: inst_bge,
                             bltu: inst_bltu, bgeu: inst_bgeu};
        ctrl.br_offs     = {inst[9:0], inst[25:10]};
        ctrl.invalid     = ~known;
    end

    always_comb begin
        a_alu_onehot: assert final ($onehot0(ctrl.alu_op));
    end

endmodule

// File: source/isa_pkg.sv
`include "id_defines.svh"

package isa_pkg;

    typedef logic [`XLEN-1:0]   word_t;
    typedef logic [`REG_AW-1:0] reg_addr_t;
    typedef logic [`ALU_OPS-1:0] alu_op_t;

    // bit positions in alu_op_t.
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    typedef enum logic [1:0] {
        MEM_NONE = 2'd0,
        MEM_BYTE = 2'd1,
        MEM_HALF = 2'd2,
        MEM_WORD = 2'd3
    } mem_size_t;

    typedef struct packed {
        logic [5:0] op_31_26;
        logic [3:0] op_25_22;
        logic [1:0] op_21_20;
        logic [4:0] op_19_15;
        reg_addr_t  rk;
        reg_addr_t  rj;
        reg_addr_t  rd;
    } inst_fields_t;

    typedef struct packed {
        logic jirl;
        logic b;
        logic bl;
        logic beq;
        logic bne;
        logic blt;
        logic bge;
        logic bltu;
        logic bgeu;
    } br_kind_t;

    typedef struct packed {
        alu_op_t    alu_op;
        logic       src1_is_pc;
        logic       src2_is_imm;
        mem_size_t  ld_size;
        logic       ld_signed;
        mem_size_t  st_size;
        logic       gr_we;
        reg_addr_t  dest;
        word_t      imm;
        br_kind_t   br_kind;
        logic [25:0] br_offs;  // raw offs26 field, the low 16 bits are offs16.
        logic       invalid;
    } dec_ctrl_t;

endpackage

// File: source/operand_forward.sv
`include "id_defines.svh"

module operand_forward
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  logic      uses_rj,
    input  logic      uses_rkd,
    input  word_t     rf_rdata1,
    input  word_t     rf_rdata2,
    input  fwd_t      ex_fwd,
    input  fwd_t      mem_fwd,
    input  fwd_t      wb_fwd,
    input  logic      ex_is_load,
    output word_t     rj_value,
    output word_t     rkd_value,
    output logic      stall
);

    function automatic logic hit(fwd_t src, reg_addr_t addr, logic used);
        return used && src.valid && src.dest != `REG_AW'(`ZERO_REG) && src.dest == addr;
    endfunction

    // youngest producer wins.
    function automatic word_t pick(fwd_t ex, fwd_t mem, fwd_t wb,
                                   reg_addr_t addr, logic used, word_t rf_value);
        word_t value;
        if (hit(ex, addr, used)) value = ex.value;
        else if (hit(mem, addr, used)) value = mem.value;
        else if (hit(wb, addr, used)) value = wb.value;
        else value = rf_value;
        return value;
    endfunction

    always_comb begin
        rj_value  = pick(ex_fwd, mem_fwd, wb_fwd, raddr1, uses_rj, rf_rdata1);
        rkd_value = pick(ex_fwd, mem_fwd, wb_fwd, raddr2, uses_rkd, rf_rdata2);
    end

    // load data is not ready until memory, so wait one cycle.
    assign stall = ex_is_load && (hit(ex_fwd, raddr1, uses_rj) || hit(ex_fwd, raddr2, uses_rkd));

endmodule

// File: source/pipe_pkg.sv
package pipe_pkg;

    import isa_pkg::*;

    // fetch to decode.
    typedef struct packed {
        word_t pc;
        word_t inst;
    } if_id_t;

    // decode to execute.
    typedef struct packed {
        word_t     pc;
        word_t     rj_value;
        word_t     rkd_value;
        word_t     imm;
        alu_op_t   alu_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        mem_size_t ld_size;
        logic      ld_signed;
        mem_size_t st_size;
        reg_addr_t dest;
        logic      gr_we;
        logic      invalid;
    } id_ex_t;

    // result bypass from a later stage. A dest of zero never matches.
    typedef struct packed {
        reg_addr_t dest;
        word_t     value;
        logic      valid;
    } fwd_t;

    // redirect to fetch, target only meaningful while taken is high.
    typedef struct packed {
        logic  taken;
        word_t target;
    } br_t;

endpackage

// File: tb.f
+incdir+source
+incdir+bench
source/isa_pkg.sv
source/pipe_pkg.sv
source/inst_decoder.sv
source/operand_forward.sv
source/branch_resolve.sv
source/id_stage.sv
bench/tb_id_stage.sv
